// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_btb -f sim.f
	./obj_dir/Vtb_btb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation did not pass"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: logic/bp_pkg.sv
package bp_pkg;

    localparam int vaddr_size      = 32;
    localparam int inst_offset     = 2;
    localparam int btb_way         = 4;
    localparam int btb_bank_width  = 2;
    localparam int btb_set         = 64;
    localparam int btb_set_width   = 6;
    localparam int btb_tag_size    = 8;
    localparam int tag_offset      = inst_offset + btb_bank_width + btb_set_width;
    localparam int upd_queue_depth = 4;

    typedef enum logic [1:0] {
        br_cond   = 2'd0,
        br_direct = 2'd1,
        br_call   = 2'd2,
        br_ret    = 2'd3
    } br_kind_t;

    typedef struct packed {
        logic                  en;
        br_kind_t              kind;
        logic [vaddr_size-1:0] target;
    } btb_entry_t;

    typedef struct packed {
        logic [btb_tag_size-1:0] tag;
        btb_entry_t              entry;
    } btb_line_t;

    typedef struct packed {
        logic [vaddr_size-1:0] start_addr;
        btb_entry_t            entry;
    } btb_update_t;

    typedef struct packed {
        logic                  hit;
        br_kind_t              kind;
        logic [vaddr_size-1:0] target;
    } btb_resp_t;

    // PC folding, shared by the lookup and update paths
    function automatic logic [btb_bank_width-1:0] pc_bank(input logic [vaddr_size-1:0] pc);
        return pc[inst_offset +: btb_bank_width];
    endfunction

    function automatic logic [btb_set_width-1:0] pc_index(input logic [vaddr_size-1:0] pc);
        return pc[inst_offset + btb_bank_width +: btb_set_width];
    endfunction

    function automatic logic [btb_tag_size-1:0] pc_tag(input logic [vaddr_size-1:0] pc);
        return pc[tag_offset +: btb_tag_size] ^ pc[vaddr_size-1 -: btb_tag_size];
    endfunction

endpackage

// File: logic/btb_bank.sv
module btb_bank (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rd_en,
    input  logic                             wr_en,
    input  logic [bp_pkg::btb_set_width-1:0] rd_addr,
    input  logic [bp_pkg::btb_set_width-1:0] wr_addr,
    input  bp_pkg::btb_line_t                wr_line,
    output bp_pkg::btb_line_t                rd_line
);
    import bp_pkg::*;

    btb_line_t          mem [btb_set];
    logic [btb_set-1:0] valid;
    btb_line_t          rd_q;
    logic               rd_valid_q;

    // Data array, read sees old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_line;
        end
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid      <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid[wr_addr] <= 1'b1;
            end
            if (rd_en) begin
                rd_valid_q <= valid[rd_addr];    // Held with the data when idle
            end
        end
    end

    // Unwritten slots never report a valid entry
    always_comb begin
        rd_line          = rd_q;
        rd_line.entry.en = rd_q.entry.en & rd_valid_q;
    end

endmodule

// File: logic/btb_hit_check.sv
module btb_hit_check (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_valid,
    input  bp_pkg::btb_line_t               rd_line,
    input  logic [bp_pkg::btb_tag_size-1:0] rd_tag,
    output logic                            resp_valid,
    output bp_pkg::btb_resp_t               resp
);
    import bp_pkg::*;

    logic tag_match;
    logic hit;

    assign tag_match = (rd_line.tag == rd_tag);
    assign hit       = rd_valid & rd_line.entry.en & tag_match;    // Bank output holds when idle

    always_comb begin
        resp     = '0;
        resp.hit = hit;
        if (hit) begin
            resp.kind   = rd_line.entry.kind;
            resp.target = rd_line.entry.target;
        end
    end

    assign resp_valid = rd_valid;

endmodule

// File: logic/btb_store.sv
module btb_store (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            lookup_valid,
    input  logic [bp_pkg::vaddr_size-1:0]   lookup_pc,
    input  logic                            wr_valid,
    input  bp_pkg::btb_update_t             wr_req,
    output logic                            rd_valid,
    output bp_pkg::btb_line_t               rd_line,
    output logic [bp_pkg::btb_tag_size-1:0] rd_tag
);
    import bp_pkg::*;

    logic [btb_set_width-1:0]  rd_index;
    logic [btb_set_width-1:0]  wr_index;
    logic [btb_bank_width-1:0] rd_bank;
    logic [btb_bank_width-1:0] wr_bank;
    logic [btb_bank_width-1:0] s2_bank;
    logic [btb_tag_size-1:0]   lookup_tag;
    logic [btb_tag_size-1:0]   wr_tag;
    logic [btb_way-1:0]        bank_rd_en;
    logic [btb_way-1:0]        bank_wr_en;
    btb_line_t                 wr_line;
    btb_line_t                 bank_rd_line [btb_way];

    // Stage one, folding of both PCs
    assign rd_bank    = pc_bank(lookup_pc);
    assign rd_index   = pc_index(lookup_pc);
    assign lookup_tag = pc_tag(lookup_pc);
    assign wr_bank    = pc_bank(wr_req.start_addr);
    assign wr_index   = pc_index(wr_req.start_addr);
    assign wr_tag     = pc_tag(wr_req.start_addr);

    assign wr_line.tag   = wr_tag;
    assign wr_line.entry = wr_req.entry;

    always_comb begin
        bank_rd_en = '0;
        bank_wr_en = '0;
        if (lookup_valid) begin
            bank_rd_en[rd_bank] = 1'b1;
        end
        // Invalid updates drain without touching the bank
        if (wr_valid && wr_req.entry.en) begin
            bank_wr_en[wr_bank] = 1'b1;
        end
    end

    for (genvar i = 0; i < btb_way; i++) begin : g_bank
        btb_bank u_bank (
            .clk     (clk),
            .reset   (reset),
            .rd_en   (bank_rd_en[i]),
            .wr_en   (bank_wr_en[i]),
            .rd_addr (rd_index),
            .wr_addr (wr_index),
            .wr_line (wr_line),
            .rd_line (bank_rd_line[i])
        );
    end

    // Stage two bookkeeping
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            s2_bank <= rd_bank;
            rd_tag  <= lookup_tag;
        end
    end

    assign rd_line = bank_rd_line[s2_bank];

endmodule

// File: logic/btb_top.sv
module btb_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          lookup_valid,
    input  logic [bp_pkg::vaddr_size-1:0] lookup_pc,
    input  logic                          update_valid,
    input  bp_pkg::btb_update_t           update_req,
    output logic                          resp_valid,
    output bp_pkg::btb_resp_t             resp,
    output logic                          update_dropped
);
    import bp_pkg::*;

    logic                    wr_valid;
    btb_update_t             wr_req;
    logic                    rd_valid;
    btb_line_t               rd_line;
    logic [btb_tag_size-1:0] rd_tag;

    btb_update_queue u_queue (
        .clk            (clk),
        .reset          (reset),
        .update_valid   (update_valid),
        .update_req     (update_req),
        .wr_valid       (wr_valid),
        .wr_req         (wr_req),
        .update_dropped (update_dropped)
    );

    btb_store u_store (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .wr_valid     (wr_valid),
        .wr_req       (wr_req),
        .rd_valid     (rd_valid),
        .rd_line      (rd_line),
        .rd_tag       (rd_tag)
    );

    btb_hit_check u_hit_check (
        .clk        (clk),
        .reset      (reset),
        .rd_valid   (rd_valid),
        .rd_line    (rd_line),
        .rd_tag     (rd_tag),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// File: logic/btb_update_queue.sv
module btb_update_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                update_valid,
    input  bp_pkg::btb_update_t update_req,
    output logic                wr_valid,
    output bp_pkg::btb_update_t wr_req,
    output logic                update_dropped
);
    import bp_pkg::*;

    btb_update_t                        mem [upd_queue_depth];
    logic [$clog2(upd_queue_depth)-1:0] rd_ptr;
    logic [$clog2(upd_queue_depth)-1:0] wr_ptr;
    logic [$clog2(upd_queue_depth):0]   count;
    logic                               full;
    logic                               push;
    logic                               pop;

    assign full = (count == upd_queue_depth);
    assign pop  = (count != '0);              // Head leaves every cycle it is present
    assign push = update_valid & (~full | pop);

    assign wr_valid = pop;
    assign wr_req   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= update_req;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            update_dropped <= 1'b0;
        end else if (update_valid && full && !pop) begin
            update_dropped <= 1'b1;
        end
    end

endmodule

// File: sim.f
logic/bp_pkg.sv
logic/btb_bank.sv
logic/btb_update_queue.sv
logic/btb_store.sv
logic/btb_hit_check.sv
logic/btb_top.sv
test/btb_props.sv
test/tb_btb.sv

// File: test/btb_input.txt
# U addr kind target en | L addr hit kind target | D dropped | I idle_cycles
# addr and target in hex, others decimal; kind 0 cond, 1 direct, 2 call, 3 ret
# Cold BTB misses everywhere
L 00001234 0 0 00000000
L 00000000 0 0 00000000
L fffffffc 0 0 00000000
L 00020000 0 0 00000000
# Bank 1, index 23, tag 04
U 00001234 1 80001000 1
I 1
L 00001234 1 1 80001000
# Same bank and index, tag 05
L 01001234 0 0 00000000
# Tag slice 05 folded with top byte 01 gives tag 04 again
L 01001634 1 1 80001000
# Bank 2 neighbour and index 24 neighbour
U 00001238 2 80002000 1
U 00001244 3 80003000 1
I 1
L 00001234 1 1 80001000
L 00001238 1 2 80002000
L 00001244 1 3 80003000
L 0000123c 0 0 00000000
# Update with en low leaves the entry alone
U 00001234 0 deadbeef 0
I 2
L 00001234 1 1 80001000
U 00001234 2 80004000 1
I 1
# Lookups on every cycle
L 00001234 1 2 80004000
L 00001238 1 2 80002000
L 00001244 1 3 80003000
L 01001234 0 0 00000000
L 01001634 1 2 80004000
# Six updates in a row, the queue drains one per cycle so none is dropped
U 00020000 0 90000100 1
U 00020010 1 90000200 1
U 00020020 2 90000300 1
U 00020030 3 90000400 1
U 00020040 0 90000500 1
U 00020050 1 90000600 1
D 0
I 1
L 00020000 1 0 90000100
L 00020010 1 1 90000200
L 00020020 1 2 90000300
L 00020030 1 3 90000400
L 00020040 1 0 90000500
L 00020050 1 1 90000600

// File: test/btb_props.sv
module btb_props (
    input logic              clk,
    input logic              reset,
    input logic              lookup_valid,
    input logic              resp_valid,
    input bp_pkg::btb_resp_t resp,
    input logic              update_dropped
);

    // One cycle lookup latency
    resp_follows_lookup: assert property (
        @(posedge clk) !reset |=> (resp_valid == $past(lookup_valid))
    ) else $error("resp_valid is not lookup_valid delayed by one cycle");

    hit_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        resp.hit |-> resp_valid
    ) else $error("resp.hit set without resp_valid");

    dropped_is_sticky: assert property (
        @(posedge clk) disable iff (reset)
        update_dropped |=> update_dropped
    ) else $error("update_dropped fell without reset");

    quiet_after_reset: assert property (
        @(posedge clk) reset |=> !resp_valid
    ) else $error("resp_valid high in the cycle after reset");

endmodule

bind btb_top btb_props u_props (
    .clk            (clk),
    .reset          (reset),
    .lookup_valid   (lookup_valid),
    .resp_valid     (resp_valid),
    .resp           (resp),
    .update_dropped (update_dropped)
);

// File: test/tb_btb.sv
module tb_btb;
    import bp_pkg::*;

    localparam int resp_timeout = 8;    // Cycles allowed for outstanding responses

    logic                  clk;
    logic                  reset;
    logic                  lookup_valid;
    logic [vaddr_size-1:0] lookup_pc;
    logic                  update_valid;
    btb_update_t           update_req;
    logic                  resp_valid;
    btb_resp_t             resp;
    logic                  update_dropped;

    btb_resp_t             exp_q [$];
    logic [vaddr_size-1:0] pc_q [$];
    int                    errors;
    int                    timeouts;

    btb_top dut (
        .clk            (clk),
        .reset          (reset),
        .lookup_valid   (lookup_valid),
        .lookup_pc      (lookup_pc),
        .update_valid   (update_valid),
        .update_req     (update_req),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .update_dropped (update_dropped)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic idle_cycle();
        @(posedge clk);
        lookup_valid <= 1'b0;
        update_valid <= 1'b0;
    endtask

    task automatic drive_update(input logic [31:0] addr, input int kind,
                                input logic [31:0] target, input int en);
        btb_update_t req;
        req.start_addr   = addr;
        req.entry.en     = (en != 0);
        req.entry.kind   = br_kind_t'(kind[1:0]);
        req.entry.target = target;
        @(posedge clk);
        update_valid <= 1'b1;
        update_req   <= req;
        lookup_valid <= 1'b0;
    endtask

    // Expected response is queued, the monitor below pops it
    task automatic drive_lookup(input logic [31:0] addr, input int hit, input int kind,
                                input logic [31:0] target);
        btb_resp_t expected;
        expected.hit    = (hit != 0);
        expected.kind   = br_kind_t'(kind[1:0]);
        expected.target = target;
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= addr;
        update_valid <= 1'b0;
        exp_q.push_back(expected);
        pc_q.push_back(addr);
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < resp_timeout) begin
            idle_cycle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout at %0t: %0d lookup responses never arrived", $time, exp_q.size());
            timeouts++;
            exp_q.delete();
            pc_q.delete();
        end
    endtask

    task automatic check_response();
        btb_resp_t             expected;
        logic [vaddr_size-1:0] pc;
        if (exp_q.size() == 0) begin
            $display("Lookup response at %0t with no lookup outstanding", $time);
            errors++;
        end else begin
            expected = exp_q.pop_front();
            pc       = pc_q.pop_front();
            if (resp.hit !== expected.hit) begin
                $display("error at %0t: resp.hit for pc %h expected %0d got %0d",
                         $time, pc, expected.hit, resp.hit);
                errors++;
            end
            if (resp.kind !== expected.kind) begin
                $display("error at %0t: resp.kind for pc %h expected %0d got %0d",
                         $time, pc, expected.kind, resp.kind);
                errors++;
            end
            if (resp.target !== expected.target) begin
                $display("error at %0t: resp.target for pc %h expected %h got %h",
                         $time, pc, expected.target, resp.target);
                errors++;
            end
        end
    endtask

    task automatic check_dropped(input int flag);
        logic expected;
        expected = (flag != 0);
        drain_responses();
        idle_cycle();
        @(negedge clk);
        if (update_dropped !== expected) begin
            $display("error at %0t: update_dropped expected %0d got %0d",
                     $time, expected, update_dropped);
            errors++;
        end
    endtask

    task automatic report_bad_line(input logic [7:0] cmd);
        $display("Data file line for command %c has missing or unreadable fields", cmd);
        errors++;
    endtask

    task automatic run_command(input int fd, input logic [7:0] cmd);
        int             code;
        int             kind;
        int             flag;
        int             count;
        logic [31:0]    addr;
        logic [31:0]    target;
        logic [1023:0]  skip_line;
        case (cmd)
            "#": code = $fgets(skip_line, fd);
            "U": begin
                code = $fscanf(fd, "%h %d %h %d", addr, kind, target, flag);
                if (code == 4) begin
                    drive_update(addr, kind, target, flag);
                end else begin
                    report_bad_line(cmd);
                end
            end
            "L": begin
                code = $fscanf(fd, "%h %d %d %h", addr, flag, kind, target);
                if (code == 4) begin
                    drive_lookup(addr, flag, kind, target);
                end else begin
                    report_bad_line(cmd);
                end
            end
            "D": begin
                code = $fscanf(fd, "%d", flag);
                if (code == 1) begin
                    check_dropped(flag);
                end else begin
                    report_bad_line(cmd);
                end
            end
            "I": begin
                code = $fscanf(fd, "%d", count);
                if (code == 1) begin
                    drain_responses();
                    repeat (count) idle_cycle();
                end else begin
                    report_bad_line(cmd);
                end
            end
            default: begin
                $display("Unknown command character %c in the data file", cmd);
                errors++;
            end
        endcase
    endtask

    // Response monitor, sampled away from the driving edge
    initial begin
        forever begin
            @(negedge clk);
            if (resp_valid === 1'b1) begin
                check_response();
            end
        end
    end

    initial begin
        int         fd;
        int         code;
        logic       done;
        logic [7:0] cmd;
        errors       = 0;
        timeouts     = 0;
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        update_valid = 1'b0;
        update_req   = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("test/btb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/btb_input.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    run_command(fd, cmd);
                end
            end
            $fclose(fd);
        end

        drain_responses();
        idle_cycle();
        $display("Done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
